/* common/hart_pkg.sv */
package hart_pkg;

  // plain vector types for the widths that carry a meaning
  typedef logic [31:0] word_t;     // data, address or instruction word
  typedef logic [4:0]  reg_addr_t; // register index x0..x31

  localparam word_t RESET_ADDR  = 32'h0000_0000; // first fetch address after reset
  localparam word_t EBREAK_INST = 32'h0010_0073; // the only SYSTEM encoding we accept
  localparam word_t NOP_INST    = 32'h0000_0013; // addi x0, x0, 0

  // major opcodes of the kept RV32I subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLT = 4'd5, // signed compare
    ALU_SLL = 4'd6,
    ALU_SRL = 4'd7
  } alu_op_e;

  // source of the register writeback value
  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_IMM = 2'd2, // lui takes the U immediate as is
    WB_PC4 = 2'd3  // link address of jal
  } wb_sel_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;   // second alu operand is the immediate, not rs2
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;    // conditional branch, beq unless branch_ne
    logic    branch_ne;
    logic    jal;
    wb_sel_e wb_sel;
    logic    halt;      // ebreak
    logic    illegal;   // encoding outside the kept subset
  } ctrl_t;

  // fetch register contents handed to execute
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t inst;
  } fetch_t;

  typedef struct packed {
    word_t addr;
    logic  ren;
    logic  wen;
    word_t wdata;
  } dmem_req_t;

  typedef struct packed {
    logic      valid;
    word_t     inst;
    word_t     pc;
    word_t     next_pc;
    reg_addr_t rd_waddr;
    word_t     rd_wdata;
    logic      halt;
  } retire_t;

endpackage

/* execute/alu.sv */
`timescale 1ns/100ps

module alu (
  input  hart_pkg::alu_op_e i_op,
  input  hart_pkg::word_t   i_a,
  input  hart_pkg::word_t   i_b,
  output hart_pkg::word_t   o_result
);

  logic [4:0] shamt;
  logic       less;

  assign shamt = i_b[4:0];                   // upper bits of the shift amount are ignored
  assign less  = $signed(i_a) < $signed(i_b); // slt and slti compare as signed

  always_comb begin
    case (i_op)
      hart_pkg::ALU_ADD: o_result = i_a + i_b;
      hart_pkg::ALU_SUB: o_result = i_a - i_b;
      hart_pkg::ALU_AND: o_result = i_a & i_b;
      hart_pkg::ALU_OR:  o_result = i_a | i_b;
      hart_pkg::ALU_XOR: o_result = i_a ^ i_b;
      hart_pkg::ALU_SLT: o_result = {31'b0, less};
      hart_pkg::ALU_SLL: o_result = i_a << shamt;
      hart_pkg::ALU_SRL: o_result = i_a >> shamt; // logical, zero fill
      default:           o_result = '0;           // unused encodings of the 4-bit op
    endcase
  end

endmodule

/* execute/decoder.sv */
`timescale 1ns/100ps

module decoder (
  input  hart_pkg::word_t i_inst,
  output hart_pkg::ctrl_t o_ctrl,
  output hart_pkg::word_t o_imm
);

  logic [2:0]      funct3;
  logic [6:0]      funct7;
  hart_pkg::word_t imm_i;
  hart_pkg::word_t imm_s;
  hart_pkg::word_t imm_b;
  hart_pkg::word_t imm_u;
  hart_pkg::word_t imm_j;
  hart_pkg::ctrl_t ctrl;

  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  // all immediates are sign extended from bit 31
  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    ctrl        = '0;               // every enable off by default
    ctrl.alu_op = hart_pkg::ALU_ADD;
    ctrl.wb_sel = hart_pkg::WB_ALU;
    o_imm       = '0;
    case (hart_pkg::opcode_e'(i_inst[6:0]))
      hart_pkg::OPC_OP: begin
        ctrl.reg_write = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: ctrl.alu_op = hart_pkg::ALU_ADD;
          10'b0100000_000: ctrl.alu_op = hart_pkg::ALU_SUB;
          10'b0000000_111: ctrl.alu_op = hart_pkg::ALU_AND;
          10'b0000000_110: ctrl.alu_op = hart_pkg::ALU_OR;
          10'b0000000_100: ctrl.alu_op = hart_pkg::ALU_XOR;
          10'b0000000_010: ctrl.alu_op = hart_pkg::ALU_SLT;
          10'b0000000_001: ctrl.alu_op = hart_pkg::ALU_SLL;
          10'b0000000_101: ctrl.alu_op = hart_pkg::ALU_SRL;
          default:         ctrl.illegal = 1'b1; // sra, sltu and friends are not kept
        endcase
      end
      hart_pkg::OPC_OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        o_imm          = imm_i;
        case (funct3)
          3'b000:  ctrl.alu_op = hart_pkg::ALU_ADD;
          3'b111:  ctrl.alu_op = hart_pkg::ALU_AND;
          3'b110:  ctrl.alu_op = hart_pkg::ALU_OR;
          3'b100:  ctrl.alu_op = hart_pkg::ALU_XOR;
          3'b010:  ctrl.alu_op = hart_pkg::ALU_SLT;
          default: ctrl.illegal = 1'b1; // immediate shifts and sltiu
        endcase
      end
      hart_pkg::OPC_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = hart_pkg::WB_IMM;
        o_imm          = imm_u;
      end
      hart_pkg::OPC_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.use_imm   = 1'b1;      // address is rs1 plus offset through the alu
        ctrl.wb_sel    = hart_pkg::WB_MEM;
        ctrl.illegal   = (funct3 != 3'b010); // lw only
        o_imm          = imm_i;
      end
      hart_pkg::OPC_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        ctrl.illegal   = (funct3 != 3'b010); // sw only
        o_imm          = imm_s;
      end
      hart_pkg::OPC_BRANCH: begin
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = funct3[0]; // 000 beq, 001 bne
        ctrl.illegal   = (funct3[2:1] != 2'b00);
        o_imm          = imm_b;
      end
      hart_pkg::OPC_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.jal       = 1'b1;
        ctrl.wb_sel    = hart_pkg::WB_PC4;
        o_imm          = imm_j;
      end
      hart_pkg::OPC_SYSTEM: begin
        ctrl.halt    = (i_inst == hart_pkg::EBREAK_INST);
        ctrl.illegal = (i_inst != hart_pkg::EBREAK_INST); // ecall and csr ops
      end
      default: ctrl.illegal = 1'b1;
    endcase
    if (ctrl.illegal) begin
      // an unknown word must not touch any architectural state
      ctrl.reg_write = 1'b0;
      ctrl.mem_write = 1'b0;
      ctrl.mem_read  = 1'b0;
      ctrl.branch    = 1'b0;
      ctrl.jal       = 1'b0;
    end
    o_ctrl = ctrl;
  end

endmodule

/* execute/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
  input  logic                i_clk,
  input  logic                i_rst,
  input  hart_pkg::fetch_t    i_fetch,
  input  hart_pkg::word_t     i_dmem_rdata, // valid in the same cycle as ren
  output hart_pkg::dmem_req_t o_dmem_req,
  output logic                o_redirect,
  output hart_pkg::word_t     o_target,
  output logic                o_halt,
  output hart_pkg::retire_t   o_retire
);

  hart_pkg::ctrl_t     ctrl;
  hart_pkg::word_t     imm;
  hart_pkg::word_t     rs1_rdata;
  hart_pkg::word_t     rs2_rdata;
  hart_pkg::word_t     alu_b;
  hart_pkg::word_t     alu_result;
  hart_pkg::word_t     pc_plus4;
  hart_pkg::word_t     wb_data;
  hart_pkg::reg_addr_t rd;
  logic                rd_wen;
  logic                taken;

  assign rd = i_fetch.inst[11:7];

  decoder u_decoder (
    .i_inst (i_fetch.inst),
    .o_ctrl (ctrl),
    .o_imm  (imm)
  );

  assign rd_wen = i_fetch.valid && ctrl.reg_write; // an empty fetch register writes nothing

  reg_file u_reg_file (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rs1_raddr (i_fetch.inst[19:15]),
    .i_rs2_raddr (i_fetch.inst[24:20]),
    .i_rd_wen    (rd_wen),
    .i_rd_waddr  (rd),
    .i_rd_wdata  (wb_data),
    .o_rs1_rdata (rs1_rdata),
    .o_rs2_rdata (rs2_rdata)
  );

  assign alu_b = ctrl.use_imm ? imm : rs2_rdata;

  alu u_alu (
    .i_op     (ctrl.alu_op),
    .i_a      (rs1_rdata),
    .i_b      (alu_b),
    .o_result (alu_result)
  );

  // beq takes on equal, bne on not equal
  assign taken      = ctrl.jal || (ctrl.branch && ((rs1_rdata == rs2_rdata) ^ ctrl.branch_ne));
  assign pc_plus4   = i_fetch.pc + 32'd4;
  assign o_target   = i_fetch.pc + imm; // B or J immediate, both pc relative
  assign o_redirect = i_fetch.valid && taken;
  assign o_halt     = i_fetch.valid && ctrl.halt;

  // word accesses only, so the alu sum is the address as is
  assign o_dmem_req.addr  = alu_result;
  assign o_dmem_req.ren   = i_fetch.valid && ctrl.mem_read;
  assign o_dmem_req.wen   = i_fetch.valid && ctrl.mem_write;
  assign o_dmem_req.wdata = rs2_rdata;

  always_comb begin
    case (ctrl.wb_sel)
      hart_pkg::WB_MEM: wb_data = i_dmem_rdata;
      hart_pkg::WB_IMM: wb_data = imm;
      hart_pkg::WB_PC4: wb_data = pc_plus4;
      default:          wb_data = alu_result;
    endcase
  end

  // every valid fetch retires here in the same cycle
  assign o_retire.valid    = i_fetch.valid;
  assign o_retire.inst     = i_fetch.inst;
  assign o_retire.pc       = i_fetch.pc;
  assign o_retire.next_pc  = taken ? o_target : pc_plus4;
  assign o_retire.rd_waddr = ctrl.reg_write ? rd : '0;
  assign o_retire.rd_wdata = wb_data;
  assign o_retire.halt     = o_halt;

  dmem_one_op: assert property (@(posedge i_clk) disable iff (i_rst)
    !(o_dmem_req.ren && o_dmem_req.wen));

  // the memory model has no byte lanes, so a misaligned access would hit the wrong word
  dmem_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_dmem_req.ren || o_dmem_req.wen) |-> (o_dmem_req.addr[1:0] == 2'b00));

  no_illegal_retire: assert property (@(posedge i_clk) disable iff (i_rst)
    o_retire.valid |-> !ctrl.illegal);

endmodule

/* execute/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
  input  logic                i_clk,
  input  logic                i_rst,
  input  hart_pkg::reg_addr_t i_rs1_raddr,
  input  hart_pkg::reg_addr_t i_rs2_raddr,
  input  logic                i_rd_wen,
  input  hart_pkg::reg_addr_t i_rd_waddr,
  input  hart_pkg::word_t     i_rd_wdata,
  output hart_pkg::word_t     o_rs1_rdata,
  output hart_pkg::word_t     o_rs2_rdata
);

  hart_pkg::word_t regs [32];

  // write lands at the edge, so the instruction after sees it through the read port
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && (i_rd_waddr != '0)) begin
      regs[i_rd_waddr] <= i_rd_wdata;
    end
  end

  // x0 is hardwired to zero on both read ports
  assign o_rs1_rdata = (i_rs1_raddr == '0) ? '0 : regs[i_rs1_raddr];
  assign o_rs2_rdata = (i_rs2_raddr == '0) ? '0 : regs[i_rs2_raddr];

endmodule

/* run.sh */
#!/bin/sh
# build the hart testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module tb_hart -o tb_hart_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_hart_sim; then
  echo "simulation ended with a failure"
  exit 1
fi

exit 0

/* source/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage (
  input  logic             i_clk,
  input  logic             i_rst,
  input  hart_pkg::word_t  i_imem_rdata, // answers o_imem_raddr in the same cycle
  input  logic             i_redirect,   // taken branch or jal retiring in execute
  input  hart_pkg::word_t  i_target,
  input  logic             i_halt,       // ebreak retiring in execute
  output hart_pkg::word_t  o_imem_raddr,
  output hart_pkg::fetch_t o_fetch
);

  hart_pkg::word_t  pc;
  hart_pkg::fetch_t fetch_q;
  logic             stopped; // latched on ebreak, only reset clears it

  assign o_imem_raddr = pc;      // pc goes straight out as the fetch address
  assign o_fetch      = fetch_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc            <= hart_pkg::RESET_ADDR;
      stopped       <= 1'b0;
      fetch_q.valid <= 1'b0;
      fetch_q.inst  <= hart_pkg::NOP_INST;
    end else if (stopped || i_halt) begin
      // once halted the pc freezes and the fetch register stays empty
      stopped       <= 1'b1;
      fetch_q.valid <= 1'b0;
      fetch_q.inst  <= hart_pkg::NOP_INST;
    end else if (i_redirect) begin
      pc            <= i_target;          // the word fetched this cycle is wrong path
      fetch_q.valid <= 1'b0;              // so it is dropped here
      fetch_q.inst  <= hart_pkg::NOP_INST;
    end else begin
      pc            <= pc + 32'd4;
      fetch_q.valid <= 1'b1;
      fetch_q.pc    <= pc;                // pc of the word being captured
      fetch_q.inst  <= i_imem_rdata;
    end
  end

  // a B or J offset may have bit 1 set and would move the pc off a word boundary
  pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst) pc[1:0] == 2'b00);

endmodule

/* source/hart.sv */
`timescale 1ns/100ps

module hart (
  input  logic                i_clk,
  input  logic                i_rst,
  input  hart_pkg::word_t     i_imem_rdata, // combinational instruction memory
  input  hart_pkg::word_t     i_dmem_rdata, // combinational data memory read
  output hart_pkg::word_t     o_imem_raddr,
  output hart_pkg::dmem_req_t o_dmem_req,
  output hart_pkg::retire_t   o_retire
);

  hart_pkg::fetch_t fetch;    // fetch register into execute
  logic             redirect; // taken branch or jal
  hart_pkg::word_t  target;
  logic             halt;     // ebreak retiring

  fetch_stage u_fetch_stage (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_imem_rdata (i_imem_rdata),
    .i_redirect   (redirect),
    .i_target     (target),
    .i_halt       (halt),
    .o_imem_raddr (o_imem_raddr),
    .o_fetch      (fetch)
  );

  execute_stage u_execute_stage (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_fetch      (fetch),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem_req   (o_dmem_req),
    .o_redirect   (redirect),
    .o_target     (target),
    .o_halt       (halt),
    .o_retire     (o_retire)
  );

endmodule

/* tb.f */
common/hart_pkg.sv
source/fetch_stage.sv
execute/decoder.sv
execute/reg_file.sv
execute/alu.sv
execute/execute_stage.sv
source/hart.sv
tests/tb_hart.sv

/* tests/tb_hart.sv */
`timescale 1ns/100ps

module tb_hart;

  logic                clk;
  logic                rst;
  hart_pkg::word_t     imem_rdata;
  hart_pkg::word_t     dmem_rdata;
  hart_pkg::word_t     imem_raddr;
  hart_pkg::dmem_req_t dmem_req;
  hart_pkg::retire_t   retire;

  hart_pkg::word_t imem [64];   // program image, also read by the shadow model
  hart_pkg::word_t dmem [64];   // data memory seen by the DUT
  hart_pkg::word_t sh_dmem [64];
  hart_pkg::word_t sh_regs [32];
  hart_pkg::word_t sh_pc;       // pc the next retire must carry
  hart_pkg::word_t halt_raddr;  // fetch address frozen by ebreak
  logic            halted;
  logic [15:0]     lfsr;
  int              n_retired;
  int              n_stores;
  int              n_loads;
  int              n_taken;
  int              n_not_taken;

  // shadow model outputs for the instruction at sh_pc
  hart_pkg::word_t     exp_inst;
  hart_pkg::word_t     exp_val;
  hart_pkg::word_t     exp_next;
  hart_pkg::word_t     exp_addr;
  hart_pkg::word_t     rs1_val;
  hart_pkg::word_t     rs2_val;
  hart_pkg::word_t     imm_i;
  hart_pkg::word_t     imm_s;
  hart_pkg::word_t     imm_b;
  hart_pkg::word_t     imm_j;
  hart_pkg::reg_addr_t exp_waddr;
  logic                exp_wen;
  logic                exp_st;
  logic                exp_ld;
  logic                exp_taken;
  logic                exp_halt;

  hart UUT (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_imem_rdata (imem_rdata),
    .i_dmem_rdata (dmem_rdata),
    .o_imem_raddr (imem_raddr),
    .o_dmem_req   (dmem_req),
    .o_retire     (retire)
  );

  always #5 clk = ~clk;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // taps 16,14,13,11
  endfunction

  // one lfsr step per immediate bit
  task automatic draw_imm12(output logic [11:0] v);
    v = '0;
    for (int i = 0; i < 12; i++) begin
      v    = {v[10:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic hart_pkg::word_t fill_word(input int idx);
    return (hart_pkg::word_t'(idx) * 32'h9E37_79B9) ^ 32'hC3C3_0000; // every index bit counts
  endfunction

  function automatic hart_pkg::word_t alu_reg_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                   input logic [4:0] rs1, input logic [2:0] f3,
                                                   input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic hart_pkg::word_t imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc}; // I format, used for op-imm and lw
  endfunction

  function automatic hart_pkg::word_t store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                                 input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic hart_pkg::word_t branch_word(input logic [12:0] imm, input logic [4:0] rs2,
                                                  input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic hart_pkg::word_t jal_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic hart_pkg::word_t lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic report_mismatch(input string name, input hart_pkg::word_t exp_v,
                                 input hart_pkg::word_t act_v);
    $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // memories answer in the same cycle, data writes land at the edge
  assign imem_rdata = imem[imem_raddr[7:2]];
  assign dmem_rdata = dmem[dmem_req.addr[7:2]];

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 64; i++) begin
        dmem[i] <= fill_word(i);
      end
    end else if (dmem_req.wen) begin
      dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
    end
  end

  // RV32I rules applied to the program word at the shadow pc
  always_comb begin
    exp_inst  = imem[sh_pc[7:2]];
    rs1_val   = sh_regs[exp_inst[19:15]];
    rs2_val   = sh_regs[exp_inst[24:20]];
    imm_i     = 32'($signed(exp_inst[31:20]));
    imm_s     = 32'($signed({exp_inst[31:25], exp_inst[11:7]}));
    imm_b     = 32'($signed({exp_inst[31], exp_inst[7], exp_inst[30:25], exp_inst[11:8], 1'b0}));
    imm_j     = 32'($signed({exp_inst[31], exp_inst[19:12], exp_inst[20], exp_inst[30:21], 1'b0}));
    exp_val   = '0;
    exp_addr  = '0;
    exp_wen   = 1'b0;
    exp_st    = 1'b0;
    exp_ld    = 1'b0;
    exp_taken = 1'b0;
    exp_halt  = 1'b0;
    exp_next  = sh_pc + 32'd4;
    case (exp_inst[6:0])
      7'b0110011: begin
        exp_wen = 1'b1;
        case (exp_inst[14:12])
          3'd0:    exp_val = exp_inst[30] ? rs1_val - rs2_val : rs1_val + rs2_val;
          3'd1:    exp_val = rs1_val << rs2_val[4:0];
          3'd2:    exp_val = ($signed(rs1_val) < $signed(rs2_val)) ? 32'd1 : 32'd0;
          3'd4:    exp_val = rs1_val ^ rs2_val;
          3'd5:    exp_val = rs1_val >> rs2_val[4:0];
          3'd6:    exp_val = rs1_val | rs2_val;
          default: exp_val = rs1_val & rs2_val;
        endcase
      end
      7'b0010011: begin
        exp_wen = 1'b1;
        case (exp_inst[14:12])
          3'd2:    exp_val = ($signed(rs1_val) < $signed(imm_i)) ? 32'd1 : 32'd0;
          3'd4:    exp_val = rs1_val ^ imm_i;
          3'd6:    exp_val = rs1_val | imm_i;
          3'd7:    exp_val = rs1_val & imm_i;
          default: exp_val = rs1_val + imm_i;
        endcase
      end
      7'b0110111: begin
        exp_wen = 1'b1;
        exp_val = {exp_inst[31:12], 12'h000};
      end
      7'b0000011: begin
        exp_wen  = 1'b1;
        exp_ld   = 1'b1;
        exp_addr = rs1_val + imm_i;
        exp_val  = sh_dmem[exp_addr[7:2]]; // last word the shadow stored there
      end
      7'b0100011: begin
        exp_st   = 1'b1;
        exp_addr = rs1_val + imm_s;
      end
      7'b1100011: begin
        exp_taken = (rs1_val == rs2_val) != exp_inst[12]; // funct3 bit 0 flips beq into bne
        if (exp_taken) begin
          exp_next = sh_pc + imm_b;
        end
      end
      7'b1101111: begin
        exp_wen   = 1'b1;
        exp_taken = 1'b1;
        exp_val   = sh_pc + 32'd4;
        exp_next  = sh_pc + imm_j;
      end
      default: exp_halt = 1'b1; // only ebreak is left in the program
    endcase
    exp_waddr = exp_wen ? exp_inst[11:7] : '0;
  end

  always @(posedge clk) begin
    if (rst) begin
      sh_pc       <= hart_pkg::RESET_ADDR;
      halted      <= 1'b0;
      halt_raddr  <= '0;
      n_retired   <= 0;
      n_stores    <= 0;
      n_loads     <= 0;
      n_taken     <= 0;
      n_not_taken <= 0;
      for (int i = 0; i < 32; i++) begin
        sh_regs[i] <= '0;
      end
      for (int i = 0; i < 64; i++) begin
        sh_dmem[i] <= fill_word(i);
      end
    end else if (retire.valid) begin
      sh_pc     <= exp_next;
      n_retired <= n_retired + 1;
      if (exp_wen && (exp_waddr != '0)) begin
        sh_regs[exp_waddr] <= exp_val;
      end
      if (exp_st) begin
        sh_dmem[exp_addr[7:2]] <= rs2_val;
        n_stores <= n_stores + 1;
      end
      if (exp_ld) n_loads <= n_loads + 1;
      if (exp_taken) n_taken <= n_taken + 1;
      if ((exp_inst[6:0] == 7'b1100011) && !exp_taken) n_not_taken <= n_not_taken + 1;
      if (exp_halt) begin
        halted     <= 1'b1;
        halt_raddr <= imem_raddr; // the pc must stay here from now on
      end
    end
  end

  reset_quiet: assert property (@(posedge clk) $past(rst) |-> !retire.valid)
    else report_mismatch("o_retire.valid", 32'd0, 32'($sampled(retire.valid)));

  pc_chain: assert property (@(posedge clk) disable iff (rst) retire.valid |-> retire.pc == sh_pc)
    else report_mismatch("o_retire.pc", $sampled(sh_pc), $sampled(retire.pc));

  inst_match: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> retire.inst == exp_inst)
    else report_mismatch("o_retire.inst", $sampled(exp_inst), $sampled(retire.inst));

  waddr_match: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> retire.rd_waddr == exp_waddr)
    else report_mismatch("o_retire.rd_waddr", 32'($sampled(exp_waddr)),
                         32'($sampled(retire.rd_waddr)));

  wdata_match: assert property (@(posedge clk) disable iff (rst)
    retire.valid && exp_wen |-> retire.rd_wdata == exp_val)
    else report_mismatch("o_retire.rd_wdata", $sampled(exp_val), $sampled(retire.rd_wdata));

  next_pc_match: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> retire.next_pc == exp_next)
    else report_mismatch("o_retire.next_pc", $sampled(exp_next), $sampled(retire.next_pc));

  halt_match: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> retire.halt == exp_halt)
    else report_mismatch("o_retire.halt", 32'($sampled(exp_halt)), 32'($sampled(retire.halt)));

  wen_match: assert property (@(posedge clk) disable iff (rst)
    dmem_req.wen == (retire.valid && exp_st))
    else report_mismatch("o_dmem_req.wen", 32'($sampled(retire.valid && exp_st)),
                         32'($sampled(dmem_req.wen)));

  ren_match: assert property (@(posedge clk) disable iff (rst)
    dmem_req.ren == (retire.valid && exp_ld))
    else report_mismatch("o_dmem_req.ren", 32'($sampled(retire.valid && exp_ld)),
                         32'($sampled(dmem_req.ren)));

  store_addr: assert property (@(posedge clk) disable iff (rst)
    dmem_req.wen |-> dmem_req.addr == exp_addr)
    else report_mismatch("o_dmem_req.addr", $sampled(exp_addr), $sampled(dmem_req.addr));

  store_data: assert property (@(posedge clk) disable iff (rst)
    dmem_req.wen |-> dmem_req.wdata == rs2_val)
    else report_mismatch("o_dmem_req.wdata", $sampled(rs2_val), $sampled(dmem_req.wdata));

  // the word fetched behind a taken transfer is dropped
  bubble_after_taken: assert property (@(posedge clk) disable iff (rst)
    retire.valid && exp_taken |=> !retire.valid)
    else report_mismatch("o_retire.valid", 32'd0, 32'($sampled(retire.valid)));

  back_to_back: assert property (@(posedge clk) disable iff (rst)
    retire.valid && !exp_taken && !exp_halt |=> retire.valid)
    else report_mismatch("o_retire.valid", 32'd1, 32'($sampled(retire.valid)));

  quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
    halted |-> !retire.valid && !dmem_req.ren && !dmem_req.wen)
    else report_mismatch("o_retire.valid/o_dmem_req.ren/o_dmem_req.wen", 32'd0,
                         32'($sampled({retire.valid, dmem_req.ren, dmem_req.wen})));

  frozen_fetch: assert property (@(posedge clk) disable iff (rst)
    halted |-> imem_raddr == halt_raddr)
    else report_mismatch("o_imem_raddr", $sampled(halt_raddr), $sampled(imem_raddr));

  initial begin
    logic [11:0] r;
    int          cycles;
    clk  = 1'b0;
    rst  = 1'b1;
    lfsr = 16'd4;
    for (int i = 0; i < 64; i++) begin
      imem[i] = hart_pkg::NOP_INST;
    end
    draw_imm12(r);
    imem[0]  = imm_word(r, 5'd0, 3'b000, 5'd1, 7'b0010011);        // addi x1
    draw_imm12(r);
    imem[1]  = imm_word(r, 5'd0, 3'b000, 5'd2, 7'b0010011);        // addi x2
    imem[2]  = alu_reg_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);      // add
    imem[3]  = alu_reg_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);      // sub
    imem[4]  = alu_reg_word(7'h00, 5'd2, 5'd1, 3'b111, 5'd5);      // and
    imem[5]  = alu_reg_word(7'h00, 5'd2, 5'd1, 3'b110, 5'd6);      // or
    imem[6]  = alu_reg_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd7);      // xor
    imem[7]  = alu_reg_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd8);      // slt
    imem[8]  = alu_reg_word(7'h00, 5'd2, 5'd1, 3'b001, 5'd9);      // sll
    imem[9]  = alu_reg_word(7'h00, 5'd2, 5'd1, 3'b101, 5'd10);     // srl
    draw_imm12(r);
    imem[10] = imm_word(r, 5'd1, 3'b111, 5'd11, 7'b0010011);       // andi
    draw_imm12(r);
    imem[11] = imm_word(r, 5'd2, 3'b110, 5'd12, 7'b0010011);       // ori
    draw_imm12(r);
    imem[12] = imm_word(r, 5'd3, 3'b100, 5'd13, 7'b0010011);       // xori
    draw_imm12(r);
    imem[13] = imm_word(r, 5'd4, 3'b010, 5'd14, 7'b0010011);       // slti
    draw_imm12(r);
    imem[14] = lui_word({r, 8'hA5}, 5'd15);
    imem[15] = store_word(12'd8, 5'd3, 5'd0);                      // sw x3, 8(x0)
    imem[16] = imm_word(12'd8, 5'd0, 3'b010, 5'd16, 7'b0000011);   // lw x16, 8(x0)
    imem[17] = branch_word(13'd8, 5'd1, 5'd1, 3'b000);             // beq taken, skips 18
    imem[18] = imm_word(12'd1, 5'd0, 3'b000, 5'd17, 7'b0010011);   // wrong path
    imem[19] = branch_word(13'd8, 5'd1, 5'd1, 3'b001);             // bne not taken
    imem[20] = jal_word(21'd8, 5'd18);                             // jal skips 21
    imem[21] = imm_word(12'd2, 5'd0, 3'b000, 5'd19, 7'b0010011);   // wrong path
    imem[22] = alu_reg_word(7'h00, 5'd18, 5'd16, 3'b000, 5'd20);   // uses load and link
    imem[23] = hart_pkg::EBREAK_INST;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    for (cycles = 0; !halted && (cycles < 200); cycles++) begin
      @(posedge clk);
    end
    if (!halted) begin
      stop_run("timeout while waiting for ebreak to retire");
    end
    for (cycles = 0; cycles < 20; cycles++) begin
      @(posedge clk);
    end
    // 24 words up to ebreak, two of them skipped by the beq and the jal
    if ((n_retired != 22) || (n_stores != 1) || (n_loads != 1) || (n_taken != 2) ||
        (n_not_taken != 1)) begin
      $display("program did not retire the expected instruction mix, %0d retired", n_retired);
      $display("Testbench failed");
      $fatal(1);
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule
